// File: testbench/spi_port_patterns.txt
// port(0 eve 1 flash) mode(0 single 1 quad out 2 quad in) width(0 8-bit 1 16-bit)
// tx word, slave reply, expected rx
0 0 0 a55a 003c a53c
1 0 0 1234 00c3 12c3
0 0 1 beef 5a96 5a96
1 0 1 0f0f 8001 8001
0 1 0 c381 0077 c377
1 1 0 7e42 00e1 7ee1
0 1 1 9abc 1357 1357
1 1 1 4d2b 2468 2468
0 2 0 55aa 00f0 55f0
1 2 0 ff00 000f ff0f
0 2 1 0000 cafe cafe
1 2 1 ffff 0001 0001
0 0 0 00ff 0000 0000
1 0 0 8000 00ff 80ff
0 0 1 0001 ffff ffff
1 0 1 6c39 a5a5 a5a5
0 1 0 2b00 0011 2b11
1 1 1 e7d4 7bde 7bde
0 2 1 3141 5926 5926
1 2 0 abcd 0099 ab99

// File: all.f
+incdir+design
design/spi_port_pkg.sv
design/io_reg_decode.sv
design/spi_engine.sv
design/spi_port_top.sv
testbench/spi_port_asserts.sv
testbench/spi_port_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := spi_port_tb
FLIST     := all.f
BIN       := obj_dir/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG); grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/spi_port_tb.sv
`timescale 1ns/1ps
`include "spi_port_settings.svh"

module spi_port_tb;
  import spi_port_pkg::*;

  localparam int NPAT      = 20;    // lines in the pattern file
  localparam int WORDS     = 6;     // port mode width tx reply rx
  localparam int RST_CYC   = 8;
  localparam int WD_CYCLES = RST_CYC + NPAT * 40;

  logic       pclk;
  logic       SCKclock = 1'b1;
  logic       io_w     = 1'b0;
  logic       io_r     = 1'b0;
  io_addr_t   io_a     = '0;
  io_data_t   io_wd    = '0;
  spi_lanes_t eve_in   = '0;
  spi_lanes_t flash_in = '0;
  io_data_t   io_rd;
  spi_pins_t  eve_pins, flash_pins;
  spi_lanes_t eve_oe, flash_oe;

  io_data_t pat_mem [NPAT*WORDS];
  int       errors = 0;
  integer   seed   = 32'h3481;

  // slave model state set up before each start
  int       xfer_id  = 0;
  int       seen_id  = 0;
  logic     act_port = 1'b0;
  logic     act_quad = 1'b0;
  logic     act_w16  = 1'b0;
  io_data_t reply    = '0;
  int       hi_cnt   = 0;     // SCK-high cycles seen
  io_data_t rec      = '0;    // bits or nibbles seen on the data lanes

  spi_port_top dut0 (
    .pclk(pclk), .SCKclock(SCKclock),
    .io_w_i(io_w), .io_r_i(io_r), .io_a_i(io_a), .io_wd_i(io_wd),
    .eve_in_i(eve_in), .flash_in_i(flash_in), .io_rd_o(io_rd),
    .eve_pins_o(eve_pins), .eve_oe_o(eve_oe),
    .flash_pins_o(flash_pins), .flash_oe_o(flash_oe)
  );

  initial begin
    pclk = 1'b0;
    forever #4 pclk = ~pclk;
  end

  // --------------------------------------------------
  // slave model that changes its reply only while SCK is low
  // --------------------------------------------------
  always @(negedge pclk) begin
    spi_pins_t  p;
    spi_lanes_t drive;
    int         sh;
    p = act_port ? flash_pins : eve_pins;
    if (xfer_id != seen_id) begin
      seen_id = xfer_id;
      hi_cnt  = 0;
      rec     = '0;
    end else if (p.sck) begin
      if (act_quad) rec = {rec[11:0], p.lanes};
      else rec = {rec[14:0], p.lanes[0]};   // MOSI
      hi_cnt = hi_cnt + 1;
    end else begin
      sh = (act_w16 ? 16 : 8) - (act_quad ? 4 : 1) * (hi_cnt + 1);
      drive = '0;
      if (sh >= 0)
        drive = act_quad ? 4'(reply >> sh) : {2'b00, 1'(reply >> sh), 1'b0};
      eve_in   <= act_port ? 4'h0 : drive;
      flash_in <= act_port ? drive : 4'h0;
    end
  end

  function automatic io_addr_t reg_addr(input logic port, input int unsigned off);
    return io_addr_t'((port ? `FLASH_SPI_BASE : `EVE_SPI_BASE) + off);
  endfunction

  task automatic bus_write(input io_addr_t a, input io_data_t d);
    io_w  = 1'b1;
    io_a  = a;
    io_wd = d;
    @(negedge pclk);
    io_w  = 1'b0;
  endtask

  task automatic bus_read(input io_addr_t a, output io_data_t d);
    io_r = 1'b1;
    io_a = a;
    @(negedge pclk);
    d = io_rd;
    io_r = 1'b0;
  endtask

  task automatic check_val(input string name, input io_data_t got, input io_data_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // --------------------------------------------------
  // stimulus and checks
  // --------------------------------------------------
  initial begin
    io_data_t  rd, tx, rep, expv, derived, exp_mosi;
    logic      port, w16;
    int        mode, polls, exp_hi;
    logic [5:0] rnd;
    spi_pins_t other_before;
    spi_lanes_t exp_oe;
    spi_lanes_t exp_in;
    $readmemh("testbench/spi_port_patterns.txt", pat_mem);
    repeat (RST_CYC) @(posedge pclk);
    @(negedge pclk);
    SCKclock = 1'b0;
    @(negedge pclk);

    for (int pi = 0; pi < 2; pi++) begin     // state after reset
      bus_read(reg_addr(pi[0], `SPI_REG_IDLE), rd);
      check_val("idle", rd, 16'h0001);
      bus_read(reg_addr(pi[0], `SPI_REG_PINS), rd);
      check_val("pins readback", rd, 16'h0000);
    end
    check_val("eve_pins_o", io_data_t'(eve_pins), 16'h0000);
    check_val("flash_pins_o", io_data_t'(flash_pins), 16'h0000);
    check_val("eve_oe_o", io_data_t'(eve_oe), 16'h000d);
    check_val("flash_oe_o", io_data_t'(flash_oe), 16'h000d);

    repeat (4) begin                        // static pins reach only their own port
      rnd = 6'($random(seed));
      bus_write(reg_addr(1'b0, `SPI_REG_PINS), 16'(rnd));
      check_val("eve_pins_o", io_data_t'(eve_pins), 16'(rnd));
      check_val("flash_pins_o", io_data_t'(flash_pins), 16'h0000);
      bus_write(reg_addr(1'b0, `SPI_REG_PINS), 16'h0000);
      bus_write(reg_addr(1'b1, `SPI_REG_PINS), 16'(rnd));
      check_val("flash_pins_o", io_data_t'(flash_pins), 16'(rnd));
      check_val("eve_pins_o", io_data_t'(eve_pins), 16'h0000);
      bus_write(reg_addr(1'b1, `SPI_REG_PINS), 16'h0000);
    end

    for (int n = 0; n < NPAT; n++) begin
      port = pat_mem[n*WORDS][0];
      mode = int'(pat_mem[n*WORDS+1]);      // 0 single, 1 quad out, 2 quad in
      w16  = pat_mem[n*WORDS+2][0];
      tx   = pat_mem[n*WORDS+3];
      rep  = pat_mem[n*WORDS+4];
      expv = pat_mem[n*WORDS+5];
      derived = w16 ? rep : {tx[15:8], rep[7:0]};
      if (derived !== expv) begin
        errors++;
        $display("pattern %0d has an expected rx that breaks the transfer rules", n);
      end
      act_port = port;
      act_quad = (mode != 0);
      act_w16  = w16;
      reply    = rep;
      xfer_id++;
      bus_write(reg_addr(port, `SPI_REG_PINS), 16'h0000);   // cs low
      bus_write(reg_addr(port, `SPI_REG_QUAD), {15'd0, mode != 0});
      bus_write(reg_addr(port, `SPI_REG_DIR), {15'd0, mode == 2});
      exp_oe = (mode == 0) ? 4'b1101 : (mode == 1) ? 4'b1111 : 4'b0000;
      check_val("oe", io_data_t'(port ? flash_oe : eve_oe), 16'(exp_oe));
      // slave already presents its first bit or nibble
      if (mode != 0)
        exp_in = w16 ? rep[15:12] : rep[7:4];
      else
        exp_in = {2'b00, w16 ? rep[15] : rep[7], 1'b0};
      bus_read(reg_addr(port, `SPI_REG_PINS), rd);
      check_val("lanes readback", rd, 16'(exp_in));
      other_before = port ? eve_pins : flash_pins;
      bus_write(reg_addr(port, w16 ? `SPI_REG_START16 : `SPI_REG_START8), tx);
      bus_read(reg_addr(~port, `SPI_REG_IDLE), rd);
      check_val("other port idle", rd, 16'h0001);
      check_val("other port pins", io_data_t'(port ? eve_pins : flash_pins),
                io_data_t'(other_before));
      polls = 0;
      do begin
        bus_read(reg_addr(port, `SPI_REG_IDLE), rd);
        polls++;
      end while (rd[0] !== 1'b1 && polls < 64);
      if (rd[0] !== 1'b1) begin
        errors++;
        $display("pattern %0d: port %0d never returned to idle", n, port);
      end
      bus_read(reg_addr(port, w16 ? `SPI_REG_START16 : `SPI_REG_START8), rd);
      check_val("rx", rd, expv);
      exp_hi = (w16 ? 16 : 8) / (mode != 0 ? 4 : 1);
      check_val("sck high cycles", 16'(hi_cnt), 16'(exp_hi));
      exp_mosi = w16 ? {tx[7:0], tx[15:8]} : {8'h00, tx[7:0]};
      if (mode != 2)
        check_val("data lanes out", rec, exp_mosi);
      bus_write(reg_addr(port, `SPI_REG_PINS), 16'h0020);   // cs high between transfers
      check_val("pins after transfer", io_data_t'(port ? flash_pins : eve_pins), 16'h0020);
    end

    $display("%0d errors in %0d patterns", errors, NPAT);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // watchdog
  initial begin
    repeat (WD_CYCLES) @(posedge pclk);
    $display("timeout: the run did not finish within %0d cycles", WD_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: testbench/spi_port_asserts.sv
`timescale 1ns/1ps

module spi_port_asserts (
  input logic pclk,
  input logic SCKclock,
  input logic start8_i,
  input logic start16_i,
  input logic idle_i,
  input logic sck_i
);

  logic [5:0] busy_cnt;   // cycles since the engine left idle

  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) busy_cnt <= '0;
    else if (idle_i) busy_cnt <= '0;
    else busy_cnt <= busy_cnt + 6'd1;
  end

  // --------------------------------------------------
  // engine protocol
  // --------------------------------------------------
  a_start_idle: assert property (@(posedge pclk) disable iff (SCKclock)
    (start8_i || start16_i) |-> idle_i) else $error("start while engine busy");

  a_sck_idle: assert property (@(posedge pclk) disable iff (SCKclock)
    idle_i |-> !sck_i) else $error("sck high while idle");

  a_busy_len: assert property (@(posedge pclk) disable iff (SCKclock)
    busy_cnt <= 6'd32) else $error("engine busy longer than 32 cycles");

endmodule

bind spi_engine spi_port_asserts u_asserts (
  .pclk(pclk), .SCKclock(SCKclock), .start8_i(start8_i), .start16_i(start16_i),
  .idle_i(idle_o), .sck_i(sck)
);

// File: design/spi_port_top.sv
`timescale 1ns/1ps

module spi_port_top (
  input  logic                  pclk,
  input  logic                  SCKclock,
  input  logic                  io_w_i,
  input  logic                  io_r_i,
  input  spi_port_pkg::io_addr_t   io_a_i,
  input  spi_port_pkg::io_data_t   io_wd_i,
  input  spi_port_pkg::spi_lanes_t eve_in_i,
  input  spi_port_pkg::spi_lanes_t flash_in_i,
  output spi_port_pkg::io_data_t   io_rd_o,
  output spi_port_pkg::spi_pins_t  eve_pins_o,
  output spi_port_pkg::spi_lanes_t eve_oe_o,
  output spi_port_pkg::spi_pins_t  flash_pins_o,
  output spi_port_pkg::spi_lanes_t flash_oe_o
);
  import spi_port_pkg::*;

  spi_cfg_t   eve_cfg,     flash_cfg;
  logic       eve_start8,  flash_start8;
  logic       eve_start16, flash_start16;
  io_data_t   eve_rx,      flash_rx;
  logic       eve_idle,    flash_idle;
  spi_lanes_t eve_lanes,   flash_lanes;

  // --------------------------------------------------
  // register decoder
  // --------------------------------------------------
  io_reg_decode u_decode (
    .pclk(pclk), .SCKclock(SCKclock),
    .io_w_i(io_w_i), .io_r_i(io_r_i), .io_a_i(io_a_i), .io_wd_i(io_wd_i),
    .eve_rx_i(eve_rx), .flash_rx_i(flash_rx),
    .eve_idle_i(eve_idle), .flash_idle_i(flash_idle),
    .eve_lanes_i(eve_lanes), .flash_lanes_i(flash_lanes),
    .io_rd_o(io_rd_o), .eve_cfg_o(eve_cfg), .flash_cfg_o(flash_cfg),
    .eve_start8_o(eve_start8), .eve_start16_o(eve_start16),
    .flash_start8_o(flash_start8), .flash_start16_o(flash_start16)
  );

  // --------------------------------------------------
  // one engine per port
  // --------------------------------------------------
  spi_engine u_eve_spi (    // display controller
    .pclk(pclk), .SCKclock(SCKclock),
    .start8_i(eve_start8), .start16_i(eve_start16), .tx_i(io_wd_i),
    .cfg_i(eve_cfg), .lanes_i(eve_in_i), .rx_o(eve_rx), .idle_o(eve_idle),
    .pins_o(eve_pins_o), .oe_o(eve_oe_o), .lanes_o(eve_lanes)
  );

  spi_engine u_flash_spi (  // serial flash
    .pclk(pclk), .SCKclock(SCKclock),
    .start8_i(flash_start8), .start16_i(flash_start16), .tx_i(io_wd_i),
    .cfg_i(flash_cfg), .lanes_i(flash_in_i), .rx_o(flash_rx), .idle_o(flash_idle),
    .pins_o(flash_pins_o), .oe_o(flash_oe_o), .lanes_o(flash_lanes)
  );

endmodule

// File: design/spi_engine.sv
`timescale 1ns/1ps
`include "spi_port_settings.svh"

module spi_engine (
  input  logic                  pclk,
  input  logic                  SCKclock,
  input  logic                  start8_i,
  input  logic                  start16_i,
  input  spi_port_pkg::io_data_t   tx_i,
  input  spi_port_pkg::spi_cfg_t   cfg_i,
  input  spi_port_pkg::spi_lanes_t lanes_i,
  output spi_port_pkg::io_data_t   rx_o,
  output logic                  idle_o,
  output spi_port_pkg::spi_pins_t  pins_o,
  output spi_port_pkg::spi_lanes_t oe_o,
  output spi_port_pkg::spi_lanes_t lanes_o
);
  import spi_port_pkg::*;

  // 8-bit transfers start halfway so they wrap after half the steps
  localparam logic [`SPI_CNT_W-1:0] CNT_HALF   = {1'b1, {(`SPI_CNT_W-1){1'b0}}};
  localparam logic [`SPI_CNT_W-1:0] STEP_SINGLE = `SPI_CNT_W'(1);
  localparam logic [`SPI_CNT_W-1:0] STEP_QUAD   = `SPI_CNT_W'(4);

  spi_state_e              state;
  logic [`SPI_CNT_W-1:0]   cnt;
  io_data_t                shifter;
  logic [`SPI_CNT_W-1:0]   cnt_next;
  logic                    sck;
  io_data_t                tx_swap;
  io_data_t                shift_in;
  spi_lanes_t              eng_lanes;
  spi_pins_t               eng_pins;

  assign cnt_next = cnt + (cfg_i.quad ? STEP_QUAD : STEP_SINGLE);
  assign sck      = cfg_i.quad ? cnt[2] : cnt[0];
  assign tx_swap  = {tx_i[7:0], tx_i[15:8]};    // low byte goes out first

  assign shift_in = cfg_i.quad ? {shifter[`IO_DATA_W-5:0], lanes_i}
                               : {shifter[`IO_DATA_W-2:0], lanes_i[1]};

  // --------------------------------------------------
  // shift FSM
  // --------------------------------------------------
  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      state   <= SPI_IDLE;
      cnt     <= '0;
      shifter <= '0;
    end else if (start8_i || start16_i) begin
      state   <= SPI_SHIFT;
      cnt     <= start8_i ? CNT_HALF : '0;
      shifter <= tx_swap;
    end else if (state == SPI_SHIFT) begin
      cnt <= cnt_next;
      if (cnt_next == '0)
        state <= SPI_IDLE;          // counter wrapped, done
      if (sck)
        shifter <= shift_in;        // sample on the high half of SCK
    end
  end

  // data lanes quiet while idle
  always_comb begin
    eng_lanes = '0;
    if (state == SPI_SHIFT)
      eng_lanes = cfg_i.quad ? shifter[`IO_DATA_W-1 -: 4]
                             : {3'b000, shifter[`IO_DATA_W-1]};
  end

  assign eng_pins = '{cs: 1'b0, sck: sck, lanes: eng_lanes};
  assign pins_o   = spi_pins_t'(cfg_i.static_pins | eng_pins);

  // single mode leaves MISO as input
  assign oe_o = cfg_i.quad ? {4{~cfg_i.dir}} : 4'b1101;

  assign rx_o    = shifter;
  assign idle_o  = (state == SPI_IDLE);
  assign lanes_o = lanes_i;     // pin readback

endmodule

// File: design/io_reg_decode.sv
`timescale 1ns/1ps
`include "spi_port_settings.svh"

module io_reg_decode (
  input  logic                  pclk,
  input  logic                  SCKclock,
  input  logic                  io_w_i,
  input  logic                  io_r_i,
  input  spi_port_pkg::io_addr_t   io_a_i,
  input  spi_port_pkg::io_data_t   io_wd_i,
  input  spi_port_pkg::io_data_t   eve_rx_i,
  input  spi_port_pkg::io_data_t   flash_rx_i,
  input  logic                  eve_idle_i,
  input  logic                  flash_idle_i,
  input  spi_port_pkg::spi_lanes_t eve_lanes_i,
  input  spi_port_pkg::spi_lanes_t flash_lanes_i,
  output spi_port_pkg::io_data_t   io_rd_o,
  output spi_port_pkg::spi_cfg_t   eve_cfg_o,
  output spi_port_pkg::spi_cfg_t   flash_cfg_o,
  output logic                  eve_start8_o,
  output logic                  eve_start16_o,
  output logic                  flash_start8_o,
  output logic                  flash_start16_o
);
  import spi_port_pkg::*;

  localparam int NPORT = 2;     // 0 = display, 1 = flash

  localparam io_addr_t PORT_BASE [NPORT] = '{`EVE_SPI_BASE, `FLASH_SPI_BASE};

  // full address match on base plus register offset
  function automatic logic reg_hit(input io_addr_t addr, input io_addr_t base,
                                   input int unsigned off);
    return addr == io_addr_t'(base + off);
  endfunction

  spi_cfg_t   cfg_q  [NPORT];
  logic       start8 [NPORT];
  logic       start16[NPORT];
  io_data_t   rx     [NPORT];
  logic       idle   [NPORT];
  spi_lanes_t lanes  [NPORT];

  assign rx[0]    = eve_rx_i;
  assign rx[1]    = flash_rx_i;
  assign idle[0]  = eve_idle_i;
  assign idle[1]  = flash_idle_i;
  assign lanes[0] = eve_lanes_i;
  assign lanes[1] = flash_lanes_i;

  // --------------------------------------------------
  // config registers: static pins, dir, quad
  // --------------------------------------------------
  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      for (int p = 0; p < NPORT; p++) cfg_q[p] <= '0;   // pins low, single mode
    end else if (io_w_i) begin
      for (int p = 0; p < NPORT; p++) begin
        if (reg_hit(io_a_i, PORT_BASE[p], `SPI_REG_PINS))
          cfg_q[p].static_pins <= spi_pins_t'(io_wd_i[$bits(spi_pins_t)-1:0]);
        if (reg_hit(io_a_i, PORT_BASE[p], `SPI_REG_DIR))
          cfg_q[p].dir <= io_wd_i[0];
        if (reg_hit(io_a_i, PORT_BASE[p], `SPI_REG_QUAD))
          cfg_q[p].quad <= io_wd_i[0];
      end
    end
  end

  // start pulses last exactly as long as the write strobe
  always_comb begin
    for (int p = 0; p < NPORT; p++) begin
      start8[p]  = io_w_i && reg_hit(io_a_i, PORT_BASE[p], `SPI_REG_START8);
      start16[p] = io_w_i && reg_hit(io_a_i, PORT_BASE[p], `SPI_REG_START16);
    end
  end

  // --------------------------------------------------
  // read mux
  // --------------------------------------------------
  always_comb begin
    io_rd_o = '0;
    if (io_r_i) begin     // data only while the read strobe is up
      for (int p = 0; p < NPORT; p++) begin
        if (reg_hit(io_a_i, PORT_BASE[p], `SPI_REG_PINS))
          io_rd_o |= io_data_t'(lanes[p]);
        if (reg_hit(io_a_i, PORT_BASE[p], `SPI_REG_START8) ||
            reg_hit(io_a_i, PORT_BASE[p], `SPI_REG_START16))
          io_rd_o |= rx[p];
        if (reg_hit(io_a_i, PORT_BASE[p], `SPI_REG_IDLE))
          io_rd_o |= io_data_t'(idle[p]);
      end
    end
  end

  assign eve_cfg_o       = cfg_q[0];
  assign flash_cfg_o     = cfg_q[1];
  assign eve_start8_o    = start8[0];
  assign eve_start16_o   = start16[0];
  assign flash_start8_o  = start8[1];
  assign flash_start16_o = start16[1];

endmodule

// File: design/spi_port_pkg.sv
`include "spi_port_settings.svh"

package spi_port_pkg;

  // --------------------------------------------------
  // bus words
  // --------------------------------------------------
  typedef logic [`IO_ADDR_W-1:0] io_addr_t;
  typedef logic [`IO_DATA_W-1:0] io_data_t;

  // data lanes IO3, IO2, MISO (IO1), MOSI (IO0)
  typedef logic [3:0] spi_lanes_t;

  // pin bundle, bit order CS SCK IO3 IO2 MISO MOSI
  typedef struct packed {
    logic       cs;
    logic       sck;
    spi_lanes_t lanes;
  } spi_pins_t;

  // per-port configuration held by the register decoder
  typedef struct packed {
    spi_pins_t static_pins;   // ORed onto the engine pins
    logic      dir;           // quad lanes are inputs when set
    logic      quad;          // 4-lane shifting
  } spi_cfg_t;

  // engine FSM
  typedef enum logic {
    SPI_IDLE,
    SPI_SHIFT
  } spi_state_e;

endpackage

// File: design/spi_port_settings.svh
`ifndef SPI_PORT_SETTINGS_SVH
`define SPI_PORT_SETTINGS_SVH

// --------------------------------------------------
// bus and engine widths
// --------------------------------------------------
`define IO_ADDR_W 12          // io bus address
`define IO_DATA_W 16          // io bus data word
`define SPI_CNT_W 5           // engine step counter

// --------------------------------------------------
// port base addresses
// --------------------------------------------------
`define EVE_SPI_BASE   12'h100  // display controller
`define FLASH_SPI_BASE 12'h110  // serial flash

// --------------------------------------------------
// register offsets within a port
// --------------------------------------------------
`define SPI_REG_PINS    0     // static pin levels, read gives lanes
`define SPI_REG_START8  1     // start 8-bit transfer, read gives rx
`define SPI_REG_START16 2     // start 16-bit transfer, read gives rx
`define SPI_REG_IDLE    3     // engine idle flag in bit 0
`define SPI_REG_DIR     4     // quad lane direction, 1 = input
`define SPI_REG_QUAD    5     // quad mode enable

`endif
